// File: alu.f
alu_fix_pkg.sv
alu_op_pkg.sv
alu_sat_arith.sv
alu_mac.sv
alu_bit_ops.sv
alu.sv
tb_alu.sv

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_in_valid,    // Instruction strobe
    output logic                o_busy,
    input  alu_op_pkg::op_e     i_inst,
    input  alu_fix_pkg::data_t  i_data_a,
    input  alu_fix_pkg::data_t  i_data_b,
    output logic                o_out_valid,   // One-cycle result pulse
    output alu_fix_pkg::data_t  o_data
);

    alu_op_pkg::alu_req_t req;
    alu_fix_pkg::data_t   arith_res;
    alu_fix_pkg::data_t   mac_res;
    alu_fix_pkg::data_t   bit_res;
    alu_fix_pkg::data_t   sel_res;
    logic                 accept;       // Instruction taken this edge
    logic                 acc_en;
    logic                 busy_q;       // High in the result cycle
    logic                 out_valid_q;
    alu_fix_pkg::data_t   data_q;

    assign req = '{op: i_inst, a: i_data_a, b: i_data_b};

    // Idle when busy_q is low
    assign accept = i_in_valid && !busy_q;
    assign acc_en = accept && (req.op == alu_op_pkg::OP_MAC);   // MAC state moves only on accept

    alu_sat_arith u_sat_arith (
        .i_a      (req.a),
        .i_b      (req.b),
        .i_sub    (req.op == alu_op_pkg::OP_SUB),
        .o_result (arith_res)
    );

    alu_mac u_mac (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_acc_en (acc_en),
        .i_a      (req.a),
        .i_b      (req.b),
        .o_result (mac_res)
    );

    alu_bit_ops u_bit_ops (
        .i_req    (req),
        .o_result (bit_res)
    );

    // Pick by op group, bit ops also cover undefined opcodes
    always_comb begin
        case (req.op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB: sel_res = arith_res;
            alu_op_pkg::OP_MAC: sel_res = mac_res;
            default:            sel_res = bit_res;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
            data_q      <= '0;
        end else begin
            busy_q      <= accept;   // Busy for exactly the result cycle
            out_valid_q <= accept;
            if (accept) begin
                data_q <= sel_res;   // Held until the next accept
            end
        end
    end

    assign o_busy      = busy_q;
    assign o_out_valid = out_valid_q;
    assign o_data      = data_q;

    // Result only appears while the unit refuses new input
    a_valid_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid |-> o_busy);

    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid |=> !o_out_valid);

endmodule

// File: alu_bit_ops.sv
`timescale 1ns/1ps

module alu_bit_ops (
    input  alu_op_pkg::alu_req_t i_req,
    output alu_fix_pkg::data_t   o_result
);

    always_comb begin
        logic [alu_fix_pkg::DATA_W-1:0]   a;       // Operands as plain bit vectors
        logic [alu_fix_pkg::DATA_W-1:0]   b;
        logic [alu_fix_pkg::DATA_W-1:0]   cpop;    // Ones in a, 0 to 16
        logic [alu_fix_pkg::DATA_W-1:0]   lrcw;
        logic [2*alu_fix_pkg::DATA_W-1:0] ror;
        logic [alu_fix_pkg::DATA_W-1:0]   clz;
        logic [alu_fix_pkg::DATA_W-1:0]   match;

        a = i_req.a;
        b = i_req.b;

        // Population count
        cpop = '0;
        for (int i = 0; i < alu_fix_pkg::DATA_W; i++) begin
            cpop = cpop + {{(alu_fix_pkg::DATA_W-1){1'b0}}, a[i]};
        end

        // Shift left cpop times, old MSB comes back inverted at bit 0
        lrcw = b;
        for (int i = 0; i < alu_fix_pkg::DATA_W; i++) begin
            if (alu_fix_pkg::DATA_W'(i) < cpop) begin
                lrcw = {lrcw[alu_fix_pkg::DATA_W-2:0], ~lrcw[alu_fix_pkg::DATA_W-1]};
            end
        end

        // Rotate via doubled word, b of 16 gives a back
        ror = {a, a} >> b;

        // Highest set bit wins, zero input keeps 16
        clz = alu_fix_pkg::DATA_W'(alu_fix_pkg::DATA_W);
        for (int i = 0; i < alu_fix_pkg::DATA_W; i++) begin
            if (a[i]) begin
                clz = alu_fix_pkg::DATA_W'(alu_fix_pkg::DATA_W - 1 - i);
            end
        end

        // Window of a against the mirrored window of b
        match = '0;
        for (int i = 0; i <= alu_fix_pkg::DATA_W - 4; i++) begin
            match[i] = (a[i+:4] == b[alu_fix_pkg::DATA_W-1-i-:4]);
        end

        case (i_req.op)
            alu_op_pkg::OP_GRAY:   o_result = a ^ (a >> 1);
            alu_op_pkg::OP_LRCW:   o_result = lrcw;
            alu_op_pkg::OP_ROR:    o_result = ror[alu_fix_pkg::DATA_W-1:0];
            alu_op_pkg::OP_CLZ:    o_result = clz;
            alu_op_pkg::OP_MATCH4: o_result = match;   // Bits 15..13 stay zero
            default:               o_result = '0;      // Arithmetic and undefined ops
        endcase
    end

endmodule

// File: alu_fix_pkg.sv
package alu_fix_pkg;

    // Q6.10 operand and result format
    localparam int DATA_W = 16;          // Operand and result width
    localparam int INT_W  = 6;           // Integer bits incl. sign
    localparam int FRAC_W = 10;          // Fraction bits

    // Signed Q6.10 word
    typedef logic signed [INT_W+FRAC_W-1:0] data_t;

    // 16-bit saturation limits
    localparam data_t DATA_MAX = 16'sh7FFF;
    localparam data_t DATA_MIN = 16'sh8000;

    // Full Q12.20 product of two operands
    localparam int PROD_W = 2 * DATA_W;

    // Q16.20 accumulator
    localparam int ACC_W      = 36;
    localparam int ACC_FRAC_W = 20;      // Same fraction as the product

    typedef logic signed [ACC_W-1:0] acc_t;

    localparam acc_t ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};   // 2^35 - 1
    localparam acc_t ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};   // -2^35

    // Half an LSB of the Q6.10 output, seen in the 10 dropped bits
    localparam int ROUND_HALF = 1 << (ACC_FRAC_W - FRAC_W - 1);

endpackage

// File: alu_mac.sv
`timescale 1ns/1ps

module alu_mac (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_acc_en,   // Accumulator update strobe
    input  alu_fix_pkg::data_t i_a,
    input  alu_fix_pkg::data_t i_b,
    output alu_fix_pkg::data_t o_result
);

    alu_fix_pkg::acc_t                        acc_q;      // Q16.20 running sum
    alu_fix_pkg::acc_t                        acc_next;
    logic signed [alu_fix_pkg::PROD_W-1:0]    prod;       // Q12.20 product
    alu_fix_pkg::acc_t                        prod_ext;
    logic signed [alu_fix_pkg::ACC_W:0]       sum;        // Extra bit for overflow
    // Sum with the 10 extra fraction bits dropped, sign taken from the guard bit
    logic signed [alu_fix_pkg::ACC_W-alu_fix_pkg::ACC_FRAC_W+alu_fix_pkg::FRAC_W:0] trunc;
    logic signed [alu_fix_pkg::ACC_W-alu_fix_pkg::ACC_FRAC_W+alu_fix_pkg::FRAC_W+1:0] rounded;
    logic                                     round_up;

    assign prod = $signed({{alu_fix_pkg::DATA_W{i_a[alu_fix_pkg::DATA_W-1]}}, i_a})
                * $signed({{alu_fix_pkg::DATA_W{i_b[alu_fix_pkg::DATA_W-1]}}, i_b});

    assign prod_ext = {{(alu_fix_pkg::ACC_W-alu_fix_pkg::PROD_W){prod[alu_fix_pkg::PROD_W-1]}},
                       prod};

    assign sum = {acc_q[alu_fix_pkg::ACC_W-1], acc_q} + {prod_ext[alu_fix_pkg::ACC_W-1], prod_ext};

    // Accumulator path saturates to 36 bits
    always_comb begin
        if (sum[alu_fix_pkg::ACC_W] == sum[alu_fix_pkg::ACC_W-1]) begin
            acc_next = sum[alu_fix_pkg::ACC_W-1:0];
        end else if (sum[alu_fix_pkg::ACC_W]) begin
            acc_next = alu_fix_pkg::ACC_MIN;
        end else begin
            acc_next = alu_fix_pkg::ACC_MAX;
        end
    end

    // Output path works on the unclamped sum
    assign trunc    = sum[alu_fix_pkg::ACC_W:alu_fix_pkg::ACC_FRAC_W-alu_fix_pkg::FRAC_W];
    assign round_up = sum[alu_fix_pkg::ACC_FRAC_W-alu_fix_pkg::FRAC_W-1:0]
                      >= alu_fix_pkg::ROUND_HALF;                        // Ties go up
    assign rounded  = trunc + $signed({1'b0, round_up});

    // Saturate to Q6.10 when the bits above the sign are not a sign extension
    always_comb begin
        if (!rounded[$high(rounded)] && |rounded[$high(rounded)-1:alu_fix_pkg::DATA_W-1]) begin
            o_result = alu_fix_pkg::DATA_MAX;
        end else if (rounded[$high(rounded)] &&
                     !(&rounded[$high(rounded)-1:alu_fix_pkg::DATA_W-1])) begin
            o_result = alu_fix_pkg::DATA_MIN;
        end else begin
            o_result = rounded[alu_fix_pkg::DATA_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (i_acc_en) begin
            acc_q <= acc_next;   // Clamped value only
        end
    end

    // Top-level busy cycle keeps MAC updates at least two edges apart
    a_acc_en_spaced: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_acc_en |=> !i_acc_en);

endmodule

// File: alu_op_pkg.sv
package alu_op_pkg;

    // Opcode field width
    localparam int INST_W = 4;

    // Instruction set
    // 0011 and 1001 are unused and fall into the zero-result default
    typedef enum logic [INST_W-1:0] {
        OP_ADD    = 4'b0000,   // Saturating add
        OP_SUB    = 4'b0001,   // Saturating subtract
        OP_MAC    = 4'b0010,   // Multiply-accumulate
        OP_GRAY   = 4'b0100,   // Binary to Gray
        OP_LRCW   = 4'b0101,   // Popcount-driven rotate with complement
        OP_ROR    = 4'b0110,   // Right rotate
        OP_CLZ    = 4'b0111,   // Leading-zero count
        OP_MATCH4 = 4'b1000    // Reverse 4-bit window match
    } op_e;

    // One accepted instruction
    typedef struct packed {
        op_e                op;   // Operation
        alu_fix_pkg::data_t a;    // First operand
        alu_fix_pkg::data_t b;    // Second operand, shift amount for ROR
    } alu_req_t;

endpackage

// File: alu_sat_arith.sv
`timescale 1ns/1ps

module alu_sat_arith (
    input  alu_fix_pkg::data_t i_a,
    input  alu_fix_pkg::data_t i_b,
    input  logic               i_sub,     // 1: a - b, 0: a + b
    output alu_fix_pkg::data_t o_result
);

    logic signed [alu_fix_pkg::DATA_W:0] ext_a;    // One guard bit above the sign
    logic signed [alu_fix_pkg::DATA_W:0] ext_b;
    logic signed [alu_fix_pkg::DATA_W:0] sum;

    assign ext_a = {i_a[alu_fix_pkg::DATA_W-1], i_a};
    assign ext_b = {i_b[alu_fix_pkg::DATA_W-1], i_b};

    // 17-bit result cannot wrap
    assign sum = i_sub ? (ext_a - ext_b) : (ext_a + ext_b);

    // Guard bit and sign bit differ only on overflow
    always_comb begin
        if (sum[alu_fix_pkg::DATA_W] == sum[alu_fix_pkg::DATA_W-1]) begin
            o_result = sum[alu_fix_pkg::DATA_W-1:0];   // In range
        end else if (sum[alu_fix_pkg::DATA_W]) begin
            o_result = alu_fix_pkg::DATA_MIN;          // Negative overflow
        end else begin
            o_result = alu_fix_pkg::DATA_MAX;          // Positive overflow
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the ALU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu -f alu.f -Mdir obj_dir -o sim_alu > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_alu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb_alu.sv
`timescale 1ns/1ps

module tb_alu;

    localparam int     TIMEOUT_CYCLES = 20;                 // Max cycles to wait for a result
    localparam longint ACC_MAX_L      = 64'sd34359738367;   // 2^35 - 1
    localparam longint ACC_MIN_L      = -64'sd34359738368;  // -2^35

    logic               i_clk;
    logic               i_rst_n;
    logic               i_in_valid;
    logic               o_busy;
    alu_op_pkg::op_e    i_inst;
    alu_fix_pkg::data_t i_data_a;
    alu_fix_pkg::data_t i_data_b;
    logic               o_out_valid;
    alu_fix_pkg::data_t o_data;

    logic [31:0] lfsr_q = 32'h2e0cf45b;   // Stimulus generator state
    longint      acc_model;               // Q16.20 accumulator of the reference model

    alu i_alu (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .o_busy      (o_busy),
        .i_inst      (i_inst),
        .i_data_a    (i_data_a),
        .i_data_b    (i_data_b),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;   // 40 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    // Up to 16 fresh bits, right aligned
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};   // One step per bit
        end
        return v;
    endfunction

    function automatic logic [15:0] clamp16(input longint v);
        if (v > 32767) return 16'h7FFF;
        if (v < -32768) return 16'h8000;
        return v[15:0];
    endfunction

    // Expected result of every non-MAC opcode
    function automatic logic [15:0] model_result(input alu_op_pkg::alu_req_t r);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic        found;
        a   = r.a;
        b   = r.b;
        res = '0;
        case (r.op)
            alu_op_pkg::OP_ADD: res = clamp16(longint'(r.a) + longint'(r.b));
            alu_op_pkg::OP_SUB: res = clamp16(longint'(r.a) - longint'(r.b));
            alu_op_pkg::OP_GRAY: res = a ^ {1'b0, a[15:1]};
            alu_op_pkg::OP_LRCW: begin
                res = b;
                for (int i = 0; i < $countones(a); i++) begin
                    res = {res[14:0], ~res[15]};   // Inverted MSB wraps to bit 0
                end
            end
            alu_op_pkg::OP_ROR: begin
                if (b <= 16) begin
                    res = a;
                    for (int i = 0; i < b; i++) begin
                        res = {res[0], res[15:1]};   // LSB wraps to the top
                    end
                end else if (b < 32) begin
                    res = a >> (b - 16);   // Only the upper copy of a is left
                end
            end
            alu_op_pkg::OP_CLZ: begin
                found = 1'b0;
                for (int i = 15; i >= 0; i--) begin
                    if (a[i]) found = 1'b1;
                    else if (!found) res = res + 16'd1;
                end
            end
            alu_op_pkg::OP_MATCH4: begin
                for (int i = 0; i <= 12; i++) begin
                    res[i] = (a[i+3 -: 4] == b[15-i -: 4]);
                end
            end
            default: res = '0;   // Undefined opcodes
        endcase
        return res;
    endfunction

    // MAC model, accumulator moves to the clamped sum
    function automatic logic [15:0] mac_expect(input alu_fix_pkg::data_t a,
                                               input alu_fix_pkg::data_t b);
        longint sum;
        longint trunc;
        sum   = acc_model + longint'(a) * longint'(b);
        trunc = sum >>> 10;
        if ((sum & 1023) >= 512) trunc = trunc + 1;   // Half rounds up
        if (sum > ACC_MAX_L) acc_model = ACC_MAX_L;
        else if (sum < ACC_MIN_L) acc_model = ACC_MIN_L;
        else acc_model = sum;
        return clamp16(trunc);
    endfunction

    task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, msg, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Hold the strobe until the result pulse shows up
    task automatic issue_op(input alu_op_pkg::op_e op, input alu_fix_pkg::data_t a,
                            input alu_fix_pkg::data_t b, output logic [15:0] res);
        int cycles;
        i_inst     = op;
        i_data_a   = a;
        i_data_b   = b;
        i_in_valid = 1'b1;
        cycles     = 0;
        do begin
            @(posedge i_clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: no result pulse for opcode %b", op);
                $display("Test failed");
                $fatal(1);
            end
        end while (!o_out_valid);
        i_in_valid = 1'b0;
        check_eq(o_busy, 1'b1, "busy during result cycle");
        res = o_data;
    endtask

    task automatic run_check(input alu_op_pkg::op_e op, input alu_fix_pkg::data_t a,
                             input alu_fix_pkg::data_t b);
        alu_op_pkg::alu_req_t r;
        logic [15:0]          got;
        r = '{op: op, a: a, b: b};
        issue_op(op, a, b, got);
        check_eq(got, model_result(r), $sformatf("%s a=%h b=%h", op.name(), a, b));
    endtask

    task automatic mac_step(input alu_fix_pkg::data_t a, input alu_fix_pkg::data_t b,
                            output logic [15:0] got);
        logic [15:0] exp;
        exp = mac_expect(a, b);
        issue_op(alu_op_pkg::OP_MAC, a, b, got);
        check_eq(got, exp, $sformatf("MAC a=%h b=%h", a, b));
    endtask

    task automatic test_arith();
        check_eq(o_busy, 1'b0, "busy after reset");
        check_eq(o_out_valid, 1'b0, "valid after reset");
        check_eq(o_data, 16'h0000, "data after reset");
        run_check(alu_op_pkg::OP_ADD, 16'sh7FFF, 16'sh0001);   // Positive overflow
        run_check(alu_op_pkg::OP_SUB, 16'sh8000, 16'sh0001);   // Negative overflow
        run_check(alu_op_pkg::OP_ADD, 16'sh8000, 16'sh8000);
        run_check(alu_op_pkg::OP_SUB, 16'sh7FFF, 16'sh8000);
        for (int i = 0; i < 20; i++) begin
            run_check(alu_op_pkg::OP_ADD, rand_bits(16), rand_bits(16));
            run_check(alu_op_pkg::OP_SUB, rand_bits(16), rand_bits(16));
        end
    endtask

    task automatic test_mac();
        logic [15:0] got;
        mac_step(16'sh0001, 16'sh0200, got);   // Sum 512 exactly, rounds to 1
        mac_step(16'shFFFF, 16'sh0400, got);   // Sum -512, tie rounds to 0
        for (int i = 0; i < 16; i++) begin
            mac_step(rand_bits(16), rand_bits(16), got);
        end
        for (int i = 0; i < 40; i++) begin
            mac_step(16'sh8000, 16'sh8000, got);   // +2^30 per step
        end
        check_eq(acc_model == ACC_MAX_L, 1'b1, "model accumulator at max");
        check_eq(got, 16'h7FFF, "MAC output saturated");
    endtask

    task automatic test_bit_ops();
        alu_fix_pkg::data_t a;
        for (int i = 0; i < 10; i++) begin
            run_check(alu_op_pkg::OP_GRAY, rand_bits(16), rand_bits(16));
            run_check(alu_op_pkg::OP_LRCW, rand_bits(16), rand_bits(16));
            run_check(alu_op_pkg::OP_MATCH4, rand_bits(16), rand_bits(16));
        end
        run_check(alu_op_pkg::OP_MATCH4, 16'sh000F, 16'shF000);   // Window 0 hits
        a = rand_bits(16);
        for (int s = 0; s <= 16; s++) begin
            run_check(alu_op_pkg::OP_ROR, a, alu_fix_pkg::data_t'(s));
        end
        run_check(alu_op_pkg::OP_CLZ, 16'sh0000, 16'sh0000);      // All zero gives 16
        run_check(alu_op_pkg::OP_CLZ, 16'shFFFF, 16'sh0000);
        for (int i = 0; i < 10; i++) begin
            run_check(alu_op_pkg::OP_CLZ, rand_bits(16) >> rand_bits(4), 16'sh0000);
        end
    endtask

    task automatic test_undefined();
        logic [3:0]  codes [8] = '{4'h3, 4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
        logic [15:0] got;
        mac_step(16'sh0123, 16'sh0456, got);
        for (int i = 0; i < 8; i++) begin
            issue_op(alu_op_pkg::op_e'(codes[i]), rand_bits(16), rand_bits(16), got);
            check_eq(got, 16'h0000, $sformatf("undefined opcode %b", codes[i]));
        end
        mac_step(16'shFF00, 16'sh0321, got);   // Accumulator must be untouched
    endtask

    task automatic test_stream();
        alu_op_pkg::op_e      ops [7] = '{alu_op_pkg::OP_ADD, alu_op_pkg::OP_SUB,
                                          alu_op_pkg::OP_GRAY, alu_op_pkg::OP_LRCW,
                                          alu_op_pkg::OP_ROR, alu_op_pkg::OP_CLZ,
                                          alu_op_pkg::OP_MATCH4};
        alu_op_pkg::alu_req_t held;
        logic                 exp_valid;
        int                   pulses;
        @(posedge i_clk);
        #2;                                    // Idle from here on
        exp_valid = 1'b0;
        pulses    = 0;
        for (int k = 0; k < 24; k++) begin
            held       = '{op: ops[rand_bits(3) % 7], a: rand_bits(16), b: rand_bits(16)};
            i_inst     = held.op;
            i_data_a   = held.a;
            i_data_b   = held.b;
            i_in_valid = 1'b1;
            @(posedge i_clk);
            #2;
            exp_valid = !exp_valid;            // Accept every second edge
            check_eq(o_out_valid, exp_valid, "stream valid pattern");
            if (o_out_valid) begin
                check_eq(o_busy, 1'b1, "stream busy with valid");
                check_eq(o_data, model_result(held), "stream result");
                pulses++;
            end
        end
        i_in_valid = 1'b0;
        check_eq(16'(pulses), 16'd12, "stream pulse count");
    endtask

    task automatic test_midrun_reset();
        logic [15:0] got;
        mac_step(rand_bits(16), rand_bits(16), got);
        i_rst_n = 1'b0;                        // Hit reset in the result cycle
        #1;
        check_eq(o_busy, 1'b0, "busy in reset");
        check_eq(o_out_valid, 1'b0, "valid in reset");
        repeat (4) @(posedge i_clk);
        #2;
        i_rst_n   = 1'b1;
        acc_model = 0;
        mac_step(16'sh0200, 16'sh0C00, got);   // From zero accumulator
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_in_valid = 1'b0;
        i_inst     = alu_op_pkg::OP_ADD;
        i_data_a   = '0;
        i_data_b   = '0;
        acc_model  = 0;
        repeat (4) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        test_arith();
        test_mac();
        test_bit_ops();
        test_midrun_reset();
        test_undefined();
        test_stream();
        $display("Test completed successfully");
        $finish;
    end

endmodule
